/* compile.f */
src/exu_pkg.sv
src/exu_alu.sv
src/exu_bypass.sv
src/exu_stage.sv
src/exu_mem_stage.sv
src/exu_top.sv
verif/exu_chk.sv
verif/exu_checker.sv
verif/exu_tb.sv

/* src/exu_alu.sv */
`timescale 1ns/10ps

module exu_alu (
    input  exu_pkg::alu_op_e alu_op,
    input  logic             double_cal,
    input  exu_pkg::word_t   src_a,
    input  exu_pkg::word_t   src_b,
    input  exu_pkg::word_t   cmp_a,
    input  exu_pkg::word_t   cmp_b,
    output exu_pkg::word_t   result,
    output logic             flag
);
    import exu_pkg::*;

    logic [4:0] shamt;

    assign shamt = src_b[4:0];

    always_comb begin
        result = '0;
        flag   = 1'b0;
        if (double_cal) begin
            // Branch: the adder forms pc + imm while the compare decides taken
            result = src_a + src_b;
            case (alu_op)
                alu_eq:  flag = (cmp_a == cmp_b);
                alu_ne:  flag = (cmp_a != cmp_b);
                alu_lt:  flag = ($signed(cmp_a) < $signed(cmp_b));
                alu_ge:  flag = ($signed(cmp_a) >= $signed(cmp_b));
                alu_ltu: flag = (cmp_a < cmp_b);
                alu_geu: flag = (cmp_a >= cmp_b);
                default: flag = 1'b0;
            endcase
        end else begin
            case (alu_op)
                alu_add:    result = src_a + src_b;
                alu_sub:    result = src_a - src_b;
                alu_and:    result = src_a & src_b;
                alu_or:     result = src_a | src_b;
                alu_xor:    result = src_a ^ src_b;
                alu_sll:    result = src_a << shamt;
                alu_srl:    result = src_a >> shamt;
                alu_sra:    result = word_t'($signed(src_a) >>> shamt);
                alu_slt: begin
                    result = {31'd0, $signed(src_a) < $signed(src_b)};
                end
                alu_sltu: begin
                    result = {31'd0, src_a < src_b};
                end
                alu_pass_b: result = src_b;
                default:    result = src_a + src_b;
            endcase
        end
    end

endmodule

/* src/exu_bypass.sv */
`timescale 1ns/10ps

module exu_bypass #(
    parameter int BYPASS_DEPTH = 4
) (
    input  logic              clk,
    input  logic              rst,
    input  exu_pkg::reg_idx_t rs1,
    input  exu_pkg::reg_idx_t rs2,
    input  exu_pkg::word_t    src1_r,
    input  exu_pkg::word_t    src2_r,
    output exu_pkg::word_t    src1,
    output exu_pkg::word_t    src2,
    output logic              wait_load,
    input  logic              push,
    input  exu_pkg::reg_idx_t push_rd,
    input  exu_pkg::word_t    push_data,
    input  logic              push_is_load,
    input  logic              load_done,
    input  exu_pkg::word_t    rdata
);
    import exu_pkg::*;

    typedef struct packed {
        reg_idx_t rd;
        word_t    data;
        logic     valid;
        logic     pending;
    } byp_entry_t;

    // Entry 0 is the youngest
    byp_entry_t hist      [BYPASS_DEPTH];
    byp_entry_t hist_next [BYPASS_DEPTH];
    logic       wait1;
    logic       wait2;
    int         fill_idx;

    // --------------------------------------------------
    // Operand lookup, walking oldest to youngest so the youngest match wins
    always_comb begin
        src1  = src1_r;
        src2  = src2_r;
        wait1 = 1'b0;
        wait2 = 1'b0;
        for (int i = BYPASS_DEPTH - 1; i >= 0; i--) begin
            if (hist[i].valid && (hist[i].rd == rs1) && (rs1 != '0)) begin
                src1  = hist[i].data;
                wait1 = hist[i].pending;
            end
            if (hist[i].valid && (hist[i].rd == rs2) && (rs2 != '0)) begin
                src2  = hist[i].data;
                wait2 = hist[i].pending;
            end
        end
    end

    assign wait_load = wait1 | wait2;

    // --------------------------------------------------
    // Load data lands in the oldest pending entry, then a push shifts
    always_comb begin
        hist_next = hist;
        fill_idx  = -1;
        for (int i = 0; i < BYPASS_DEPTH; i++) begin
            if (hist[i].valid && hist[i].pending) begin
                fill_idx = i;
            end
        end
        if (load_done && (fill_idx >= 0)) begin
            hist_next[fill_idx].data    = rdata;
            hist_next[fill_idx].pending = 1'b0;
        end
        if (push) begin
            for (int i = BYPASS_DEPTH - 1; i > 0; i--) begin
                hist_next[i] = hist_next[i-1];
            end
            hist_next[0] = '{rd: push_rd, data: push_data, valid: 1'b1, pending: push_is_load};
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < BYPASS_DEPTH; i++) begin
                hist[i] <= '0;
            end
        end else begin
            hist <= hist_next;
        end
    end

endmodule

/* src/exu_mem_stage.sv */
`timescale 1ns/10ps

module exu_mem_stage #(
    parameter int MEM_WORDS = 64
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              exu_valid,
    input  exu_pkg::exu_out_t exu_out,
    output logic              lsu_ready,
    output logic              load_done,
    output exu_pkg::word_t    rdata,
    output logic              wb_valid,
    output exu_pkg::wb_t      wb
);
    import exu_pkg::*;

    localparam int ADDR_W = $clog2(MEM_WORDS);

    typedef enum logic {st_idle, st_load} mem_state_e;

    mem_state_e        state;
    word_t             ram [MEM_WORDS];
    logic [ADDR_W-1:0] acc_addr;
    logic [ADDR_W-1:0] load_addr;
    reg_idx_t          load_rd;
    logic              accept;

    assign lsu_ready = (state == st_idle);
    assign accept    = exu_valid && lsu_ready;
    // Byte address in, word index out
    assign acc_addr  = exu_out.result[ADDR_W+1:2];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= st_idle;
            wb_valid  <= 1'b0;
            load_done <= 1'b0;
            for (int i = 0; i < MEM_WORDS; i++) begin
                ram[i] <= '0;
            end
        end else begin
            wb_valid  <= 1'b0;
            load_done <= 1'b0;
            case (state)
                st_idle: begin
                    if (accept) begin
                        if (exu_out.inst_s) begin
                            ram[acc_addr] <= exu_out.store_data;
                        end
                        if (exu_out.inst_l) begin
                            state <= st_load;
                        end else if (exu_out.gpr_we) begin
                            wb_valid <= 1'b1;
                        end
                    end
                end
                st_load: begin
                    wb_valid  <= 1'b1;
                    load_done <= 1'b1;
                    state     <= st_idle;
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            load_addr <= acc_addr;
            load_rd   <= exu_out.rd;
            if (!exu_out.inst_l) begin
                wb <= '{rd: exu_out.rd, data: exu_out.result};
            end
        end
        if (state == st_load) begin
            rdata <= ram[load_addr];
            wb    <= '{rd: load_rd, data: ram[load_addr]};
        end
    end

endmodule

/* src/exu_pkg.sv */
package exu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;

    // Branch compares reuse the set-less-than codes, selected by double_cal
    typedef enum logic [3:0] {
        alu_add    = 4'd0,
        alu_sub    = 4'd1,
        alu_and    = 4'd2,
        alu_or     = 4'd3,
        alu_xor    = 4'd4,
        alu_sll    = 4'd5,
        alu_srl    = 4'd6,
        alu_sra    = 4'd7,
        alu_slt    = 4'd8,
        alu_sltu   = 4'd9,
        alu_pass_b = 4'd10,
        alu_eq     = 4'd11,
        alu_ne     = 4'd12,
        alu_ge     = 4'd13,
        alu_geu    = 4'd14
    } alu_op_e;

    localparam alu_op_e alu_lt  = alu_slt;
    localparam alu_op_e alu_ltu = alu_sltu;

    typedef struct packed {
        word_t    pc;
        word_t    imm;
        reg_idx_t rd;
        reg_idx_t rs1;
        reg_idx_t rs2;
        word_t    src1_r;
        word_t    src2_r;
        alu_op_e  alu_op;
        logic     src1_is_pc;
        logic     src2_is_imm;
        logic     double_cal;
        logic     is_jump;
        logic     gpr_we;
        logic     inst_l;
        logic     inst_s;
    } dec_inst_t;

    typedef struct packed {
        reg_idx_t rd;
        logic     gpr_we;
        logic     inst_l;
        logic     inst_s;
        word_t    result;
        word_t    store_data;
    } exu_out_t;

    typedef struct packed {
        reg_idx_t rd;
        word_t    data;
    } wb_t;

endpackage

/* src/exu_stage.sv */
`timescale 1ns/10ps

module exu_stage #(
    parameter int BYPASS_DEPTH = 4
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               in_valid,
    input  exu_pkg::dec_inst_t in_inst,
    output logic               in_ready,
    input  logic               lsu_ready,
    input  logic               load_done,
    input  exu_pkg::word_t     rdata,
    input  logic               pc_update,
    output logic               exu_valid,
    output exu_pkg::exu_out_t  exu_out,
    output logic               redirect_valid,
    output exu_pkg::word_t     redirect_pc
);
    import exu_pkg::*;

    word_t src1;
    word_t src2;
    word_t alu_a;
    word_t alu_b;
    word_t alu_result;
    word_t link_pc;
    word_t target;
    word_t exe_result;
    logic  alu_flag;
    logic  wait_load;
    logic  accept;
    logic  live;
    logic  taken;

    exu_bypass #(
        .BYPASS_DEPTH (BYPASS_DEPTH)
    ) i_exu_bypass (
        .clk          (clk),
        .rst          (rst),
        .rs1          (in_inst.rs1),
        .rs2          (in_inst.rs2),
        .src1_r       (in_inst.src1_r),
        .src2_r       (in_inst.src2_r),
        .src1         (src1),
        .src2         (src2),
        .wait_load    (wait_load),
        .push         (live && in_inst.gpr_we),
        .push_rd      (in_inst.rd),
        .push_data    (in_inst.inst_l ? '0 : exe_result),
        .push_is_load (in_inst.inst_l),
        .load_done    (load_done),
        .rdata        (rdata)
    );

    assign alu_a = in_inst.src1_is_pc ? in_inst.pc : src1;
    assign alu_b = in_inst.src2_is_imm ? in_inst.imm : src2;

    exu_alu i_exu_alu (
        .alu_op     (in_inst.alu_op),
        .double_cal (in_inst.double_cal),
        .src_a      (alu_a),
        .src_b      (alu_b),
        .cmp_a      (src1),
        .cmp_b      (src2),
        .result     (alu_result),
        .flag       (alu_flag)
    );

    assign in_ready = lsu_ready && !wait_load;
    assign accept   = in_valid && in_ready;
    // Anything accepted under a pending redirect is on the wrong path
    assign live     = accept && !redirect_valid;

    assign link_pc    = in_inst.pc + 32'd4;
    assign taken      = in_inst.is_jump || (in_inst.double_cal && alu_flag);
    assign target     = in_inst.is_jump ? {alu_result[31:1], 1'b0} : alu_result;
    assign exe_result = in_inst.is_jump ? link_pc : alu_result;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            exu_valid      <= 1'b0;
            redirect_valid <= 1'b0;
        end else begin
            if (lsu_ready) begin
                exu_valid <= live;
            end
            if (redirect_valid) begin
                if (pc_update) begin
                    redirect_valid <= 1'b0;
                end
            end else if (live && taken && (target != link_pc)) begin
                redirect_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (live) begin
            exu_out <= '{rd: in_inst.rd, gpr_we: in_inst.gpr_we, inst_l: in_inst.inst_l,
                         inst_s: in_inst.inst_s, result: exe_result, store_data: src2};
            if (taken) begin
                redirect_pc <= target;
            end
        end
    end

endmodule

/* src/exu_top.sv */
`timescale 1ns/10ps

module exu_top #(
    parameter int BYPASS_DEPTH = 4,
    parameter int MEM_WORDS    = 64
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               in_valid,
    input  exu_pkg::dec_inst_t in_inst,
    output logic               in_ready,
    input  logic               pc_update,
    output logic               redirect_valid,
    output exu_pkg::word_t     redirect_pc,
    output logic               wb_valid,
    output exu_pkg::wb_t       wb
);
    import exu_pkg::*;

    logic     exu_valid;
    exu_out_t exu_out;
    logic     lsu_ready;
    logic     load_done;
    word_t    rdata;

    exu_stage #(
        .BYPASS_DEPTH (BYPASS_DEPTH)
    ) i_exu_stage (
        .clk            (clk),
        .rst            (rst),
        .in_valid       (in_valid),
        .in_inst        (in_inst),
        .in_ready       (in_ready),
        .lsu_ready      (lsu_ready),
        .load_done      (load_done),
        .rdata          (rdata),
        .pc_update      (pc_update),
        .exu_valid      (exu_valid),
        .exu_out        (exu_out),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

    exu_mem_stage #(
        .MEM_WORDS (MEM_WORDS)
    ) i_exu_mem_stage (
        .clk       (clk),
        .rst       (rst),
        .exu_valid (exu_valid),
        .exu_out   (exu_out),
        .lsu_ready (lsu_ready),
        .load_done (load_done),
        .rdata     (rdata),
        .wb_valid  (wb_valid),
        .wb        (wb)
    );

endmodule

/* verif/exu_checker.sv */
`timescale 1ns/10ps

module exu_checker (
    input  logic           clk,
    input  logic           rst,
    input  logic           wb_valid,
    input  exu_pkg::wb_t   wb,
    input  logic           redirect_valid,
    input  exu_pkg::word_t redirect_pc
);
    import exu_pkg::*;

    wb_t   wb_q         [$];
    int    wb_test_q    [$];
    word_t redir_q      [$];
    int    redir_test_q [$];
    logic  redirect_seen;
    int    errors = 0;

    task automatic expect_wb(input int test, input reg_idx_t rd, input word_t data);
        wb_q.push_back('{rd: rd, data: data});
        wb_test_q.push_back(test);
    endtask

    task automatic expect_redirect(input int test, input word_t pc);
        redir_q.push_back(pc);
        redir_test_q.push_back(test);
    endtask

    function automatic int pending_count();
        return wb_q.size() + redir_q.size();
    endfunction

    // --------------------------------------------------
    task automatic check_wb();
        wb_t exp;
        int  test;
        if (wb_q.size() == 0) begin
            $display("unexpected writeback to x%0d with data %h", wb.rd, wb.data);
            errors++;
        end else begin
            exp  = wb_q.pop_front();
            test = wb_test_q.pop_front();
            if (wb.rd !== exp.rd) begin
                $display("** Error test %0d: wb.rd = %h, expected %h", test, wb.rd, exp.rd);
                errors++;
            end
            if (wb.data !== exp.data) begin
                $display("** Error test %0d: wb.data = %h, expected %h",
                         test, wb.data, exp.data);
                errors++;
            end
        end
    endtask

    task automatic check_redirect();
        word_t exp;
        int    test;
        if (redir_q.size() == 0) begin
            $display("unexpected redirect to %h", redirect_pc);
            errors++;
        end else begin
            exp  = redir_q.pop_front();
            test = redir_test_q.pop_front();
            if (redirect_pc !== exp) begin
                $display("** Error test %0d: redirect_pc = %h, expected %h",
                         test, redirect_pc, exp);
                errors++;
            end
        end
    endtask

    // Outputs are sampled on the rising edge, where they are stable
    always @(posedge clk or posedge rst) begin
        if (rst) begin
            redirect_seen <= 1'b0;
        end else begin
            redirect_seen <= redirect_valid;
            if (wb_valid) begin
                check_wb();
            end
            if (redirect_valid && !redirect_seen) begin
                check_redirect();
            end
        end
    end

endmodule

/* verif/exu_chk.sv */
`timescale 1ns/10ps

module exu_chk (
    input logic               clk,
    input logic               rst,
    input logic               in_valid,
    input exu_pkg::dec_inst_t in_inst,
    input logic               in_ready,
    input logic               pc_update,
    input logic               redirect_valid,
    input logic               wb_valid,
    input logic               load_done
);
    import exu_pkg::*;

    int unsigned fail_count = 0;
    logic        load_busy;
    reg_idx_t    load_rd;

    // Follows the youngest accepted writer while it is a load still waiting for its data
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            load_busy <= 1'b0;
            load_rd   <= '0;
        end else if (in_valid && in_ready && !redirect_valid && in_inst.gpr_we) begin
            load_busy <= in_inst.inst_l && (in_inst.rd != '0);
            load_rd   <= in_inst.rd;
        end else if (load_done) begin
            load_busy <= 1'b0;
        end
    end

    // --------------------------------------------------
    reset_quiet: assert property (@(posedge clk)
        $fell(rst) |-> (!redirect_valid && !wb_valid && !load_done && in_ready))
        else begin
            $error("control output high in the first cycle after reset");
            fail_count++;
        end

    // A redirect is only dropped by the fetch acknowledge
    redirect_hold: assert property (@(posedge clk) disable iff (rst)
        (redirect_valid && !pc_update) |=> redirect_valid)
        else begin
            $error("redirect_valid dropped without pc_update");
            fail_count++;
        end

    load_single_wb: assert property (@(posedge clk) disable iff (rst)
        load_done |-> !$past(wb_valid))
        else begin
            $error("wb_valid high in two consecutive cycles around a load");
            fail_count++;
        end

    stall_ready: assert property (@(posedge clk) disable iff (rst)
        (load_busy && ((in_inst.rs1 == load_rd) || (in_inst.rs2 == load_rd))) |-> !in_ready)
        else begin
            $error("in_ready high while an operand still waits for load data");
            fail_count++;
        end

endmodule

bind exu_top exu_chk i_exu_chk (
    .clk            (clk),
    .rst            (rst),
    .in_valid       (in_valid),
    .in_inst        (in_inst),
    .in_ready       (in_ready),
    .pc_update      (pc_update),
    .redirect_valid (redirect_valid),
    .wb_valid       (wb_valid),
    .load_done      (load_done)
);

/* verif/exu_tb.sv */
`timescale 1ns/10ps

module exu_tb;
    import exu_pkg::*;

    localparam int WAIT_LIMIT = 200;

    logic        clk;
    logic        rst;
    logic        in_valid;
    dec_inst_t   in_inst;
    logic        in_ready;
    logic        pc_update;
    logic        redirect_valid;
    word_t       redirect_pc;
    logic        wb_valid;
    wb_t         wb;

    integer      seed;
    integer      fd;
    string       line;
    logic [31:0] fld [20];
    int          n_read;
    int          cur_test;
    int          err_mark;
    int          tests_ok;
    int          tests_bad;
    bit          aborted;

    exu_top #(
        .BYPASS_DEPTH (4),
        .MEM_WORDS    (64)
    ) i_exu_top (
        .clk            (clk),
        .rst            (rst),
        .in_valid       (in_valid),
        .in_inst        (in_inst),
        .in_ready       (in_ready),
        .pc_update      (pc_update),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .wb_valid       (wb_valid),
        .wb             (wb)
    );

    exu_checker i_exu_checker (
        .clk            (clk),
        .rst            (rst),
        .wb_valid       (wb_valid),
        .wb             (wb),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // --------------------------------------------------
    // Fetch acknowledges a pending redirect after a random delay
    task automatic ack_redirect();
        int delay;
        int n;
        if (redirect_valid) begin
            delay = 1 + ($random(seed) & 3);
            repeat (delay) @(negedge clk);
            pc_update = 1'b1;
            @(negedge clk);
            pc_update = 1'b0;
            n = 0;
            while (redirect_valid && n < WAIT_LIMIT) begin
                @(negedge clk);
                n++;
            end
            if (redirect_valid) begin
                $display("test %0d: redirect_valid did not drop after pc_update", cur_test);
                aborted = 1'b1;
            end
        end
    endtask

    task automatic issue_inst();
        int n;
        bit accepted;
        in_valid            = 1'b1;
        in_inst.pc          = fld[1];
        in_inst.imm         = fld[2];
        in_inst.rd          = fld[3][4:0];
        in_inst.rs1         = fld[4][4:0];
        in_inst.rs2         = fld[5][4:0];
        in_inst.src1_r      = fld[6];
        in_inst.src2_r      = fld[7];
        in_inst.alu_op      = alu_op_e'(fld[8][3:0]);
        in_inst.src1_is_pc  = fld[9][0];
        in_inst.src2_is_imm = fld[10][0];
        in_inst.double_cal  = fld[11][0];
        in_inst.is_jump     = fld[12][0];
        in_inst.gpr_we      = fld[13][0];
        in_inst.inst_l      = fld[14][0];
        in_inst.inst_s      = fld[15][0];
        n        = 0;
        accepted = 1'b0;
        while (!accepted && n < WAIT_LIMIT) begin
            @(posedge clk);
            accepted = in_ready;
            n++;
        end
        @(negedge clk);
        in_valid = 1'b0;
        if (!accepted) begin
            $display("test %0d: instruction at pc %h was never accepted", cur_test, fld[1]);
            aborted = 1'b1;
        end
    endtask

    task automatic finish_test();
        int n;
        if (!aborted) begin
            ack_redirect();
        end
        n = 0;
        while (!aborted && i_exu_checker.pending_count() != 0 && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (aborted) begin
            tests_bad++;
        end else if (i_exu_checker.pending_count() != 0) begin
            $display("test %0d: %0d expected events never arrived",
                     cur_test, i_exu_checker.pending_count());
            tests_bad++;
            aborted = 1'b1;
        end else if (i_exu_checker.errors != err_mark) begin
            $display("test %0d: FAILED with %0d errors", cur_test,
                     i_exu_checker.errors - err_mark);
            tests_bad++;
        end else begin
            $display("test %0d: ok", cur_test);
            tests_ok++;
        end
    endtask

    // --------------------------------------------------
    initial begin
        seed      = 32'h46aa_8029;
        rst       = 1'b1;
        in_valid  = 1'b0;
        in_inst   = '0;
        pc_update = 1'b0;
        cur_test  = 0;
        err_mark  = 0;
        tests_ok  = 0;
        tests_bad = 0;
        aborted   = 1'b0;
        repeat (10) @(negedge clk);
        rst = 1'b0;

        fd = $fopen("verif/exu_trace.txt", "r");
        if (fd == 0) begin
            $display("the trace file verif/exu_trace.txt could not be opened");
            aborted = 1'b1;
        end
        while (!aborted && !$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 1 && line.getc(0) != "#") begin
                n_read = $sscanf(line,
                    "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    fld[0], fld[1], fld[2], fld[3], fld[4], fld[5], fld[6], fld[7],
                    fld[8], fld[9], fld[10], fld[11], fld[12], fld[13], fld[14],
                    fld[15], fld[16], fld[17], fld[18], fld[19]);
                if (n_read != 20) begin
                    $display("a trace line has %0d fields instead of 20", n_read);
                    aborted = 1'b1;
                end else begin
                    if (fld[0] != cur_test) begin
                        if (cur_test != 0) begin
                            finish_test();
                        end
                        cur_test = fld[0];
                        err_mark = i_exu_checker.errors;
                    end
                    // Wrong-path lines go out while the redirect is still pending
                    if (!aborted && fld[16] != 0) begin
                        ack_redirect();
                    end
                    if (!aborted) begin
                        if (fld[16][0]) begin
                            i_exu_checker.expect_wb(cur_test, fld[17][4:0], fld[18]);
                        end
                        if (fld[16][1]) begin
                            i_exu_checker.expect_redirect(cur_test, fld[19]);
                        end
                        issue_inst();
                    end
                end
            end
        end
        if (!aborted && cur_test != 0) begin
            finish_test();
        end
        if (fd != 0) begin
            $fclose(fd);
        end
        repeat (8) @(negedge clk);

        $display("tests: %0d ok, %0d failed; checker errors %0d; assertion failures %0d",
                 tests_ok, tests_bad, i_exu_checker.errors, i_exu_top.i_exu_chk.fail_count);
        if (!aborted && tests_bad == 0 && i_exu_checker.errors == 0 &&
            i_exu_top.i_exu_chk.fail_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

/* verif/exu_trace.txt */
# test pc imm rd rs1 rs2 src1_r src2_r alu_op src1_is_pc src2_is_imm double_cal is_jump
# gpr_we inst_l inst_s kind(0 none 1 wb 2 redirect 3 both) exp_rd exp_data exp_target
1 100 0 a 1 2 80001234 f05 0 0 0 0 0 1 0 0 1 a 80002139 0
1 104 0 b 1 2 80001234 f05 1 0 0 0 0 1 0 0 1 b 8000032f 0
1 108 f05 c 1 0 80001234 0 2 0 1 0 0 1 0 0 1 c 204 0
1 10c 0 d 1 2 80001234 f05 3 0 0 0 0 1 0 0 1 d 80001f35 0
1 110 ffffffff e 1 0 80001234 0 4 0 1 0 0 1 0 0 1 e 7fffedcb 0
1 114 0 f 1 2 80001234 f05 5 0 0 0 0 1 0 0 1 f 24680 0
1 118 5 10 1 0 80001234 0 6 0 1 0 0 1 0 0 1 10 4000091 0
1 11c 404 11 1 0 80001234 0 7 0 1 0 0 1 0 0 1 11 f8000123 0
1 120 0 12 1 2 80001234 f05 8 0 0 0 0 1 0 0 1 12 1 0
1 124 ffffffff 13 1 0 80001234 0 9 0 1 0 0 1 0 0 1 13 1 0
1 128 12345000 14 0 0 0 0 a 0 1 0 0 1 0 0 1 14 12345000 0
1 12c 1000 15 0 0 0 0 0 1 1 0 0 1 0 0 1 15 112c 0
2 180 7 5 0 0 0 0 0 0 1 0 0 1 0 0 1 5 7 0
2 184 0 6 5 5 dead dead 0 0 0 0 0 1 0 0 1 6 e 0
2 188 1 5 6 0 dead 0 0 0 1 0 0 1 0 0 1 5 f 0
2 18c 0 7 5 6 dead dead 1 0 0 0 0 1 0 0 1 7 1 0
2 190 100 0 7 0 dead 0 0 0 1 0 0 1 0 0 1 0 101 0
2 194 0 8 0 7 0 dead 0 0 0 0 0 1 0 0 1 8 1 0
3 1c0 40 9 0 0 0 0 0 0 1 0 0 1 0 0 1 9 40 0
3 1c4 cafe1000 b 0 0 0 0 a 0 1 0 0 1 0 0 1 b cafe1000 0
3 1c8 8 0 9 b dead beef 0 0 1 0 0 0 0 1 0 0 0 0
3 1cc 8 c 9 0 dead 0 0 0 1 0 0 1 1 0 1 c cafe1000 0
3 1d0 1 d c 0 dead 0 0 0 1 0 0 1 0 0 1 d cafe1001 0
4 200 40 0 d d dead beef b 1 1 1 0 0 0 0 2 0 0 240
4 204 55 e 0 0 0 0 0 0 1 0 0 1 0 0 0 0 0 0
4 208 0 f d d dead dead 0 0 0 0 0 1 0 0 0 0 0 0
4 240 0 10 e 0 222 0 0 0 0 0 0 1 0 0 1 10 222 0
4 244 100 1 0 0 0 0 0 1 1 0 1 1 0 0 3 1 248 344
4 248 4 11 0 0 0 0 0 0 1 0 0 1 0 0 0 0 0 0
4 344 1 0 1 0 dead 0 0 0 1 0 1 0 0 0 2 0 0 248
5 248 80 0 10 10 dead dead c 1 1 1 0 0 0 0 0 0 0 0
5 24c 1 12 10 0 dead 0 0 0 1 0 0 1 0 0 1 12 223 0
5 250 4 0 10 12 dead dead 9 1 1 1 0 0 0 0 0 0 0 0
5 254 0 13 12 12 dead dead 0 0 0 0 0 1 0 0 1 13 446 0
